// File: compile.f
+incdir+logic
+incdir+sim
logic/aesPkg.sv
logic/sBox.sv
logic/keyExpand.sv
logic/roundDatapath.sv
logic/roundControl.sv
logic/aesEncryptCore.sv
sim/tbAesCore.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tbAesCore
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_TEXT ?= SIMULATION FAILED
PASS_TEXT ?= SIMULATION PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard logic/*.svh sim/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@$(MAKE) --no-print-directory check

check:
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
	  echo "check: the testbench reported a failure, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_TEXT)" $(LOG); then \
	  echo "check: no pass line found in $(LOG)"; exit 1; \
	else \
	  echo "check: ok"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/aesModel.svh
`ifndef AES_MODEL_SVH
`define AES_MODEL_SVH

// product in GF(2^8) modulo x^8 + x^4 + x^3 + x + 1
function automatic logic [7:0] gfMultiply(input logic [7:0] a, input logic [7:0] b);
  logic [7:0] p;
  logic [7:0] aa;
  logic [7:0] bb;
  p  = 8'h00;
  aa = a;
  bb = b;
  while (bb != 8'h00) begin
    if (bb[0]) begin
      p = p ^ aa;
    end
    aa = aa[7] ? ((aa << 1) ^ 8'h1b) : (aa << 1);
    bb = bb >> 1;
  end
  return p;
endfunction

// inverse found by search, zero stays zero
function automatic logic [7:0] subByte(input logic [7:0] a);
  logic [7:0] inv;
  inv = 8'h00;
  for (int b = 1; b < 256; b++) begin
    if (gfMultiply(a, 8'(b)) == 8'h01) begin
      inv = 8'(b);
    end
  end
  // bit i gets bits i, i+4, i+5, i+6, i+7 of the inverse
  return inv ^ {inv[3:0], inv[7:4]} ^ {inv[4:0], inv[7:5]} ^
         {inv[5:0], inv[7:6]} ^ {inv[6:0], inv[7]} ^ 8'h63;
endfunction

function automatic logic [31:0] subWord(input logic [31:0] w);
  return {subByte(w[31:24]), subByte(w[23:16]), subByte(w[15:8]), subByte(w[7:0])};
endfunction

// round key n of the standard 44-word expansion
function automatic logic [127:0] expandRoundKey(input logic [127:0] key, input int n);
  logic [31:0] w [44];
  logic [31:0] t;
  logic [7:0]  rc;
  for (int i = 0; i < 4; i++) begin
    w[i] = key[127-32*i -: 32];
  end
  rc = 8'h01;
  for (int i = 4; i < 44; i++) begin
    t = w[i-1];
    if (i % 4 == 0) begin
      t  = subWord({t[23:0], t[31:24]}) ^ {rc, 24'h000000};
      rc = gfMultiply(rc, 8'h02);
    end
    w[i] = w[i-4] ^ t;
  end
  return {w[4*n], w[4*n+1], w[4*n+2], w[4*n+3]};
endfunction

// byte i of the block is row i%4 of column i/4
function automatic logic [127:0] encryptReference(input logic [127:0] key,
                                                  input logic [127:0] pt);
  logic [7:0]   s [16];
  logic [7:0]   t [16];
  logic [127:0] rk;
  logic [127:0] ct;
  logic [7:0]   a0;
  logic [7:0]   a1;
  logic [7:0]   a2;
  logic [7:0]   a3;
  for (int i = 0; i < 16; i++) begin
    s[i] = pt[127-8*i -: 8] ^ key[127-8*i -: 8];
  end
  for (int round = 1; round <= 10; round++) begin
    rk = expandRoundKey(key, round);
    for (int i = 0; i < 16; i++) begin
      t[i] = subByte(s[i]);
    end
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        s[r+4*c] = t[r+4*((c+r)%4)];
      end
    end
    if (round != 10) begin
      for (int c = 0; c < 4; c++) begin
        a0 = s[4*c];
        a1 = s[4*c+1];
        a2 = s[4*c+2];
        a3 = s[4*c+3];
        s[4*c]   = gfMultiply(a0, 8'h02) ^ gfMultiply(a1, 8'h03) ^ a2 ^ a3;
        s[4*c+1] = a0 ^ gfMultiply(a1, 8'h02) ^ gfMultiply(a2, 8'h03) ^ a3;
        s[4*c+2] = a0 ^ a1 ^ gfMultiply(a2, 8'h02) ^ gfMultiply(a3, 8'h03);
        s[4*c+3] = gfMultiply(a0, 8'h03) ^ a1 ^ a2 ^ gfMultiply(a3, 8'h02);
      end
    end
    for (int i = 0; i < 16; i++) begin
      s[i] = s[i] ^ rk[127-8*i -: 8];
    end
  end
  for (int i = 0; i < 16; i++) begin
    ct[127-8*i -: 8] = s[i];
  end
  return ct;
endfunction

`endif

// File: sim/tbAesCore.sv
`timescale 1ns/10ps
`include "aes_consts.svh"

module tbAesCore import aesPkg::*; ();

  localparam int numRandom     = 200;
  localparam int numTests      = numRandom + 7;
  localparam int timeoutCycles = numTests * 12 + 50;

  logic        clk = 1'b0;
  logic        arstN;
  logic        validIn;
  aesBlock     key;
  aesBlock     data;
  aesBlock     dataOut;
  aesBlock     keyOut;
  logic        validOut;
  logic        busy;
  logic [31:0] rngState = 32'h386c;

  `include "aesModel.svh"

  always #10 clk = ~clk;

  aesEncryptCore i_dut (
    .clk      (clk),
    .arstN    (arstN),
    .validIn  (validIn),
    .key      (key),
    .data     (data),
    .dataOut  (dataOut),
    .keyOut   (keyOut),
    .validOut (validOut),
    .busy     (busy)
  );

  // xorshift32
  function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  function automatic aesBlock randomBlock();
    aesBlock b;
    b.flat[127:96] = nextRandom();
    b.flat[95:64]  = nextRandom();
    b.flat[63:32]  = nextRandom();
    b.flat[31:0]   = nextRandom();
    return b;
  endfunction

  task automatic checkBlock(input string name, input aesBlock expected, input aesBlock actual);
    if (actual.flat !== expected.flat) begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected.flat, actual.flat);
      $display("SIMULATION FAILED");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic checkStrobe(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected %b actual %b", name, expected, actual);
      $display("SIMULATION FAILED");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  // one block from request to result
  // preloaded means validIn was already raised by the block before
  task automatic runBlock(input string name, input aesBlock k, input aesBlock d,
                          input aesBlock expData, input aesBlock expKey,
                          input bit preloaded, input int intrudeAt, input bit chain,
                          input aesBlock nextK, input aesBlock nextD);
    if (!preloaded) begin
      @(posedge clk);
      validIn <= 1'b1;
      key     <= k;
      data    <= d;
      @(negedge clk);
      // previous strobe must be gone by now
      checkStrobe($sformatf("%s validOut idle", name), 1'b0, validOut);
      checkStrobe($sformatf("%s busy idle", name), 1'b0, busy);
    end
    @(posedge clk);
    // accepting edge, inputs are scrambled since the core should not need them
    validIn   <= 1'b0;
    key.flat  <= ~k.flat;
    data.flat <= ~d.flat;
    for (int i = 1; i <= `AES_NUM_ROUNDS; i++) begin
      @(negedge clk);
      checkStrobe($sformatf("%s busy in round %0d", name, i), 1'b1, busy);
      checkStrobe($sformatf("%s validOut in round %0d", name, i), 1'b0, validOut);
      @(posedge clk);
      if (i == intrudeAt) begin
        // request with other data that must be dropped
        validIn   <= 1'b1;
        key.flat  <= k.flat ^ d.flat;
        data.flat <= ~d.flat;
      end else if (i == `AES_NUM_ROUNDS && chain) begin
        validIn <= 1'b1;
        key     <= nextK;
        data    <= nextD;
      end else begin
        validIn <= 1'b0;
      end
    end
    @(negedge clk);
    checkStrobe($sformatf("%s validOut", name), 1'b1, validOut);
    checkStrobe($sformatf("%s busy after last round", name), 1'b0, busy);
    checkBlock($sformatf("%s dataOut", name), expData, dataOut);
    checkBlock($sformatf("%s keyOut", name), expKey, keyOut);
  endtask

  initial begin
    repeat (timeoutCycles) @(posedge clk);
    $display("timeout after %0d cycles before all tests finished", timeoutCycles);
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    aesBlock k;
    aesBlock d;
    aesBlock ed;
    aesBlock ek;
    aesBlock ck [4];
    aesBlock cd [4];
    arstN   = 1'b0;
    validIn = 1'b0;
    key     = '0;
    data    = '0;
    repeat (10) @(posedge clk);
    arstN <= 1'b1;
    @(negedge clk);
    checkStrobe("busy after reset", 1'b0, busy);
    checkStrobe("validOut after reset", 1'b0, validOut);

    // FIPS-197 appendix C.1
    k.flat  = 128'h000102030405060708090a0b0c0d0e0f;
    d.flat  = 128'h00112233445566778899aabbccddeeff;
    ed.flat = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    ek.flat = 128'h13111d7fe3944a17f307a78b4d2b30c5;
    runBlock("standard vector", k, d, ed, ek, 1'b0, -1, 1'b0, k, d);

    for (int n = 0; n < numRandom; n++) begin
      k       = randomBlock();
      d       = randomBlock();
      ed.flat = encryptReference(k.flat, d.flat);
      ek.flat = expandRoundKey(k.flat, 10);
      runBlock($sformatf("random %0d", n), k, d, ed, ek, 1'b0, -1, 1'b0, k, d);
    end

    // requests while busy, early and on the last round edge
    k       = randomBlock();
    d       = randomBlock();
    ed.flat = encryptReference(k.flat, d.flat);
    ek.flat = expandRoundKey(k.flat, 10);
    runBlock("busy early", k, d, ed, ek, 1'b0, 3, 1'b0, k, d);
    runBlock("busy late", k, d, ed, ek, 1'b0, 9, 1'b0, k, d);

    // next request in the validOut cycle
    for (int j = 0; j < 4; j++) begin
      ck[j] = randomBlock();
      cd[j] = randomBlock();
    end
    for (int j = 0; j < 4; j++) begin
      ed.flat = encryptReference(ck[j].flat, cd[j].flat);
      ek.flat = expandRoundKey(ck[j].flat, 10);
      runBlock($sformatf("back to back %0d", j), ck[j], cd[j], ed, ek,
               j > 0, -1, j < 3, ck[(j+1)%4], cd[(j+1)%4]);
    end

    @(posedge clk);
    @(negedge clk);
    checkStrobe("validOut one cycle", 1'b0, validOut);
    checkStrobe("busy at end", 1'b0, busy);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: logic/aesEncryptCore.sv
`timescale 1ns/10ps

module aesEncryptCore import aesPkg::*; (
  input  logic    clk,
  input  logic    arstN,
  input  logic    validIn,
  input  aesBlock key,
  input  aesBlock data,
  output aesBlock dataOut,
  output aesBlock keyOut,
  output logic    validOut,
  output logic    busy
);

  logic    start;
  logic    step;
  logic    lastRound;
  aesBlock roundKey;

  roundControl i_roundControl (
    .clk       (clk),
    .arstN     (arstN),
    .validIn   (validIn),
    .start     (start),
    .step      (step),
    .lastRound (lastRound),
    .busy      (busy),
    .validOut  (validOut)
  );

  // key schedule runs alongside the rounds
  keyExpand i_keyExpand (
    .clk      (clk),
    .arstN    (arstN),
    .start    (start),
    .step     (step),
    .key      (key),
    .roundKey (roundKey),
    .keyOut   (keyOut)
  );

  roundDatapath i_roundDatapath (
    .clk       (clk),
    .arstN     (arstN),
    .start     (start),
    .step      (step),
    .lastRound (lastRound),
    .data      (data),
    .key       (key),
    .roundKey  (roundKey),
    .dataOut   (dataOut)
  );

endmodule

// File: logic/roundControl.sv
`timescale 1ns/10ps
`include "aes_consts.svh"

module roundControl import aesPkg::*; (
  input  logic clk,
  input  logic arstN,
  input  logic validIn,
  output logic start,
  output logic step,
  output logic lastRound,
  output logic busy,
  output logic validOut
);

  roundIdx round;

  // validIn while busy is dropped
  assign start     = validIn && !busy;
  assign step      = busy;
  assign lastRound = (round == roundIdx'(`AES_NUM_ROUNDS));

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      round    <= '0;
      busy     <= 1'b0;
      validOut <= 1'b0;
    end else begin
      // one-cycle strobe after the final round
      validOut <= busy && lastRound;
      if (start) begin
        round <= roundIdx'(1);
        busy  <= 1'b1;
      end else if (busy) begin
        if (lastRound) begin
          round <= '0;
          busy  <= 1'b0;
        end else begin
          round <= round + roundIdx'(1);
        end
      end
    end
  end

endmodule

// File: logic/roundDatapath.sv
`timescale 1ns/10ps

module roundDatapath import aesPkg::*; (
  input  logic    clk,
  input  logic    arstN,
  input  logic    start,
  input  logic    step,
  input  logic    lastRound,
  input  aesBlock data,
  input  aesBlock key,
  input  aesBlock roundKey,
  output aesBlock dataOut
);

  aesBlock state;
  aesBlock subbed;
  aesBlock shifted;
  aesBlock mixed;
  aesBlock roundOut;

  // one column times the fixed 2 3 1 1 circulant
  function automatic aesWord mixColumn(input aesWord col);
    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] a3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
  endfunction

  // SubBytes
  for (genvar i = 0; i < 16; i++) begin : gSubBytes
    sBox i_sBox (
      .in  (state.flat[8*i +: 8]),
      .out (subbed.flat[8*i +: 8])
    );
  end

  // ShiftRows, row r rotates left by r columns
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shifted.cols[c][8*(3-r) +: 8] = subbed.cols[(c+r)%4][8*(3-r) +: 8];
      end
    end
  end

  always_comb begin
    for (int c = 0; c < 4; c++) begin
      mixed.cols[c] = mixColumn(shifted.cols[c]);
    end
  end

  // final round skips MixColumns
  assign roundOut.flat = (lastRound ? shifted.flat : mixed.flat) ^ roundKey.flat;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= '0;
    end else if (start) begin
      // initial AddRoundKey
      state.flat <= data.flat ^ key.flat;
    end else if (step) begin
      state <= roundOut;
    end
  end

  assign dataOut = state;

endmodule

// File: logic/keyExpand.sv
`timescale 1ns/10ps
`include "aes_consts.svh"

module keyExpand import aesPkg::*; (
  input  logic    clk,
  input  logic    arstN,
  input  logic    start,
  input  logic    step,
  input  aesBlock key,
  output aesBlock roundKey,
  output aesBlock keyOut
);

  aesBlock    keyQ;
  aesBlock    keyNext;
  logic [7:0] rcon;
  aesWord     rotWord;
  aesWord     subWord;

  // RotWord on the last column of the current key
  assign rotWord = {keyQ.cols[3][23:0], keyQ.cols[3][31:24]};

  for (genvar i = 0; i < 4; i++) begin : gSubWord
    sBox i_sBox (
      .in  (rotWord[8*i +: 8]),
      .out (subWord[8*i +: 8])
    );
  end

  // each word chains on the freshly derived one before it
  always_comb begin
    keyNext.cols[0] = keyQ.cols[0] ^ subWord ^ {rcon, 24'h000000};
    for (int c = 1; c < 4; c++) begin
      keyNext.cols[c] = keyQ.cols[c] ^ keyNext.cols[c-1];
    end
  end

  // datapath consumes the new key in the same step
  assign roundKey = keyNext;
  assign keyOut   = keyQ;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rcon <= `AES_RCON_FIRST;
    end else if (start) begin
      rcon <= `AES_RCON_FIRST;
    end else if (step) begin
      // 01 02 04 ... 80 1b 36
      rcon <= xtime(rcon);
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      keyQ <= key;
    end else if (step) begin
      keyQ <= keyNext;
    end
  end

endmodule

// File: logic/sBox.sv
`timescale 1ns/10ps

module sBox import aesPkg::*; (
  input  logic [7:0] in,
  output logic [7:0] out
);

  localparam logic [7:0] affineConst = 8'h63;

  logic [7:0] inverse;

  // shift-and-add product, reduced each step
  function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] shifted;
    acc     = 8'h00;
    shifted = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        acc = acc ^ shifted;
      end
      shifted = xtime(shifted);
    end
    return acc;
  endfunction

  function automatic logic [7:0] rotl(input logic [7:0] b, input int n);
    return (b << n) | (b >> (8 - n));
  endfunction

  // inverse as in^254, the product of in^2, in^4 ... in^128
  // zero maps to zero without a special case
  always_comb begin
    logic [7:0] power;
    power   = in;
    inverse = 8'h01;
    for (int k = 1; k < 8; k++) begin
      power   = gfMul(power, power);
      inverse = gfMul(inverse, power);
    end
  end

  // affine transform over GF(2)
  assign out = inverse ^ rotl(inverse, 1) ^ rotl(inverse, 2) ^ rotl(inverse, 3) ^
               rotl(inverse, 4) ^ affineConst;

endmodule

// File: logic/aesPkg.sv
`include "aes_consts.svh"

package aesPkg;

  // one column, byte 0 (row 0) in the top bits
  typedef logic [`AES_WORD_BITS-1:0] aesWord;

  // the same 128 bits seen flat or as four columns
  // column 0 sits in the most significant word
  typedef union packed {
    logic [`AES_BLOCK_BITS-1:0] flat;
    aesWord [0:3]               cols;
  } aesBlock;

  typedef logic [`AES_ROUND_BITS-1:0] roundIdx;

  // multiply by x in GF(2^8)
  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? `AES_REDUCE_POLY : 8'h00);
  endfunction

endpackage

// File: logic/aes_consts.svh
`ifndef AES_CONSTS_SVH
`define AES_CONSTS_SVH

// block and key width, a 128-bit key only
`define AES_BLOCK_BITS 128

// one state column or key word
`define AES_WORD_BITS 32

// full rounds after the initial key add
`define AES_NUM_ROUNDS 10

// wide enough to count up to AES_NUM_ROUNDS
`define AES_ROUND_BITS 4

// low byte of x^8 + x^4 + x^3 + x + 1
`define AES_REDUCE_POLY 8'h1B

// Rcon used by the first key step
`define AES_RCON_FIRST 8'h01

`endif
